// ==== Bender.yml ====
package:
  name: sauria_lite

sources:
  - include_dirs:
      - hw
    files:
      - hw/sauria_bus_pkg.sv
      - hw/sauria_addr_pkg.sv
      - hw/sauria_ifs.sv
      - hw/cfg_decoder.sv
      - hw/df_controller.sv
      - hw/dma_engine.sv
      - hw/mem_arbiter.sv
      - hw/sauria_core.sv
      - hw/sauria_subsystem.sv
  - target: test
    include_dirs:
      - hw
    files:
      - dv/tb_sauria_subsystem.sv

// ==== dv/tb_sauria_subsystem.sv ====
// One host access at a time; no debug traffic during runs, external reads answered a cycle later
`include "sauria_defs.svh"

module tb_sauria_subsystem;
    import sauria_bus_pkg::*;

    typedef enum logic [1:0] {OP_WR, OP_RD, OP_RUN} op_e;

    // Worst case cycles for one table entry
    localparam int ENTRY_CYCLES = 4 * `SAURIA_MEM_DEPTH + 20;

    logic                          i_system_clk;
    logic                          i_rst_n;
    logic                          i_cfg_wr;
    logic                          i_cfg_rd;
    logic [`SAURIA_CFG_ADDR_W-1:0] i_cfg_addr;
    word_t                         i_cfg_wdata;
    word_t                         o_cfg_rdata;
    logic                          o_cfg_rvalid;
    logic                          o_ext_rd;
    ext_addr_t                     o_ext_addr;
    word_t                         i_ext_rdata;
    logic                          o_intr;
    logic                          o_dma_intr;
    logic                          o_core_intr;

    word_t       ext_mem [2**`SAURIA_EXT_ADDR_W];
    integer      seed;
    op_e         tbl_op [$];
    logic [15:0] tbl_addr [$];
    word_t       tbl_data [$];
    word_t       tbl_exp [$];
    int          n_checks;
    int          n_errors;
    int          n_failed;
    logic        table_ready;

    sauria_subsystem dut_i (
        .i_system_clk (i_system_clk),
        .i_rst_n      (i_rst_n),
        .i_cfg_wr     (i_cfg_wr),
        .i_cfg_rd     (i_cfg_rd),
        .i_cfg_addr   (i_cfg_addr),
        .i_cfg_wdata  (i_cfg_wdata),
        .o_cfg_rdata  (o_cfg_rdata),
        .o_cfg_rvalid (o_cfg_rvalid),
        .o_ext_rd     (o_ext_rd),
        .o_ext_addr   (o_ext_addr),
        .i_ext_rdata  (i_ext_rdata),
        .o_intr       (o_intr),
        .o_dma_intr   (o_dma_intr),
        .o_core_intr  (o_core_intr)
    );

    initial begin
        i_system_clk = 1'b0;
        forever #5 i_system_clk = ~i_system_clk;
    end

    // External memory, fixed one-cycle read latency
    always @(posedge i_system_clk) begin
        if (o_ext_rd) begin
            i_ext_rdata <= ext_mem[o_ext_addr];
        end
    end

    // ------------------------------
    // Checks
    // ------------------------------
    task automatic check_word(input string name, input word_t exp, input word_t act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("[ERROR] t=%0t %s: expected 0x%08h, got 0x%08h", $time, name, exp, act);
        end
    endtask

    // Pulse count or pulse delay in cycles
    task automatic check_pulse(input string name, input int exp, input int act);
        n_checks++;
        if (act != exp) begin
            n_errors++;
            $display("[ERROR] t=%0t %s: expected %0d, got %0d", $time, name, exp, act);
        end
    endtask

    function automatic word_t sum_ext(input ext_addr_t src, input int len);
        word_t acc;
        acc = '0;
        for (int i = 0; i < len; i++) begin
            acc += ext_mem[ext_addr_t'(src + i)];
        end
        return acc;
    endfunction

    // ------------------------------
    // Host bus access
    // ------------------------------
    task automatic host_write(input logic [15:0] addr, input word_t data);
        @(posedge i_system_clk);
        i_cfg_wr    <= 1'b1;
        i_cfg_addr  <= addr;
        i_cfg_wdata <= data;
        @(posedge i_system_clk);
        i_cfg_wr <= 1'b0;
    endtask

    task automatic host_read(input logic [15:0] addr, output word_t data);
        int lat;
        @(posedge i_system_clk);
        i_cfg_rd   <= 1'b1;
        i_cfg_addr <= addr;
        @(posedge i_system_clk);
        i_cfg_rd <= 1'b0;
        @(negedge i_system_clk);
        lat = 1;
        while (!o_cfg_rvalid && lat < 6) begin
            @(negedge i_system_clk);
            lat++;
        end
        if (!o_cfg_rvalid) begin
            $display("[ERROR] t=%0t read of 0x%04h never returned rvalid", $time, addr);
        end
        data = o_cfg_rdata;
        check_pulse("o_cfg_rvalid delay", 2, lat);
    endtask

    task automatic check_idle();
        int intr_n;
        int dma_n;
        int core_n;
        int rv_n;
        intr_n = 0;
        dma_n  = 0;
        core_n = 0;
        rv_n   = 0;
        repeat (3) begin
            @(negedge i_system_clk);
            intr_n += o_intr;
            dma_n  += o_dma_intr;
            core_n += o_core_intr;
            rv_n   += o_cfg_rvalid;
        end
        check_pulse("o_intr", 0, intr_n);
        check_pulse("o_dma_intr", 0, dma_n);
        check_pulse("o_core_intr", 0, core_n);
        check_pulse("o_cfg_rvalid", 0, rv_n);
    endtask

    // START, then watch the three interrupts and read back RESULT
    task automatic run_and_wait(input logic [15:0] addr, input logic intr_exp, input word_t exp);
        int    cyc;
        int    dma_n;
        int    core_n;
        int    intr_n;
        int    dma_at;
        int    core_at;
        int    intr_at;
        word_t res;
        cyc     = 0;
        dma_n   = 0;
        core_n  = 0;
        intr_n  = 0;
        dma_at  = -1;
        core_at = -1;
        intr_at = -1;
        host_write(16'h0000, 32'h1);
        // A few cycles past the core pulse so o_intr is seen
        while (cyc < ENTRY_CYCLES && (core_at < 0 || cyc < core_at + 3)) begin
            @(negedge i_system_clk);
            cyc++;
            if (o_dma_intr) begin
                dma_n++;
                dma_at = (dma_at < 0) ? cyc : dma_at;
            end
            if (o_core_intr) begin
                core_n++;
                core_at = (core_at < 0) ? cyc : core_at;
            end
            if (o_intr) begin
                intr_n++;
                intr_at = (intr_at < 0) ? cyc : intr_at;
            end
        end
        if (core_at < 0) begin
            n_errors++;
            $display("[ERROR] t=%0t run did not finish within %0d cycles", $time, ENTRY_CYCLES);
        end
        check_pulse("o_dma_intr", 1, dma_n);
        check_pulse("o_core_intr", 1, core_n);
        check_pulse("o_intr", intr_exp ? 1 : 0, intr_n);
        if (dma_at >= core_at || (intr_exp && intr_at <= core_at)) begin
            n_errors++;
            $display("[ERROR] t=%0t interrupt pulses came out of order", $time);
        end
        host_read(addr, res);
        check_word("RESULT", exp, res);
    endtask

    // ------------------------------
    // Stimulus table
    // ------------------------------
    task automatic add_op(input op_e op, input logic [15:0] addr, input word_t data,
                          input word_t exp);
        tbl_op.push_back(op);
        tbl_addr.push_back(addr);
        tbl_data.push_back(data);
        tbl_exp.push_back(exp);
    endtask

    task automatic build_table();
        add_op(OP_RD,  16'h0001, 0, 0);
        // Register readback
        add_op(OP_WR,  16'h1000, 32'h0000_1234, 0);
        add_op(OP_RD,  16'h1000, 0, 32'h0000_1234);
        add_op(OP_WR,  16'h1001, 32'h25, 0);
        add_op(OP_RD,  16'h1001, 0, 32'h25);
        add_op(OP_WR,  16'h2000, 32'h10, 0);
        add_op(OP_RD,  16'h2000, 0, 32'h10);
        add_op(OP_RD,  16'h2001, 0, 0);
        add_op(OP_WR,  16'h0002, 32'h1, 0);
        add_op(OP_RD,  16'h0002, 0, 32'h1);
        // Debug window into local memory
        add_op(OP_WR,  16'h2045, 32'hDEAD_BEEF, 0);
        add_op(OP_WR,  16'h207F, 32'h1357_9BDF, 0);
        add_op(OP_RD,  16'h2045, 0, 32'hDEAD_BEEF);
        add_op(OP_RD,  16'h207F, 0, 32'h1357_9BDF);
        // Unmapped regions and registers
        add_op(OP_WR,  16'h3000, 32'hFFFF_FFFF, 0);
        add_op(OP_RD,  16'h3000, 0, 0);
        add_op(OP_RD,  16'hF001, 0, 0);
        add_op(OP_WR,  16'h1007, 32'h5A5A_5A5A, 0);
        add_op(OP_RD,  16'h1007, 0, 0);
        add_op(OP_RD,  16'h1000, 0, 32'h0000_1234);
        add_op(OP_RD,  16'h1001, 0, 32'h25);
        add_op(OP_RD,  16'h2000, 0, 32'h10);
        add_op(OP_RD,  16'h0005, 0, 0);
        add_op(OP_RD,  16'h2005, 0, 0);
        // Full run with the interrupt enabled
        add_op(OP_WR,  16'h1000, 32'h0100, 0);
        add_op(OP_WR,  16'h1001, 32'd16, 0);
        add_op(OP_WR,  16'h2000, 32'd16, 0);
        add_op(OP_RUN, 16'h2001, 1, sum_ext(16'h0100, 16));
        add_op(OP_RD,  16'h2040, 0, ext_mem[16'h0100]);
        add_op(OP_RD,  16'h2047, 0, ext_mem[16'h0107]);
        add_op(OP_RD,  16'h204F, 0, ext_mem[16'h010F]);
        add_op(OP_RD,  16'h0001, 0, 32'h2);
        add_op(OP_WR,  16'h0003, 32'h1, 0);
        add_op(OP_RD,  16'h0001, 0, 0);
        // Masked run over the whole memory at the top of the external space
        add_op(OP_WR,  16'h0002, 32'h0, 0);
        add_op(OP_RD,  16'h0002, 0, 0);
        add_op(OP_WR,  16'h1000, 32'hFFC0, 0);
        add_op(OP_WR,  16'h1001, 32'd64, 0);
        add_op(OP_WR,  16'h2000, 32'd64, 0);
        add_op(OP_RUN, 16'h2001, 0, sum_ext(16'hFFC0, 64));
        add_op(OP_RD,  16'h0001, 0, 32'h2);
        add_op(OP_RD,  16'h207F, 0, ext_mem[16'hFFFF]);
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin
        word_t rd_val;
        int    errs_before;
        i_rst_n     = 1'b0;
        i_cfg_wr    = 1'b0;
        i_cfg_rd    = 1'b0;
        i_cfg_addr  = '0;
        i_cfg_wdata = '0;
        i_ext_rdata = '0;
        table_ready = 1'b0;
        n_checks    = 0;
        n_errors    = 0;
        n_failed    = 0;
        seed        = 27;
        for (int i = 0; i < 2**`SAURIA_EXT_ADDR_W; i++) begin
            ext_mem[i] = $random(seed);
        end
        build_table();
        table_ready = 1'b1;
        repeat (3) @(posedge i_system_clk);
        i_rst_n <= 1'b1;

        errs_before = n_errors;
        check_idle();
        $display("after reset: %s", (n_errors == errs_before) ? "ok" : "failed");
        n_failed += (n_errors != errs_before);

        for (int t = 0; t < tbl_op.size(); t++) begin
            errs_before = n_errors;
            case (tbl_op[t])
                OP_WR: host_write(tbl_addr[t], tbl_data[t]);
                OP_RD: begin
                    host_read(tbl_addr[t], rd_val);
                    check_word($sformatf("o_cfg_rdata @0x%04h", tbl_addr[t]), tbl_exp[t], rd_val);
                end
                default: run_and_wait(tbl_addr[t], tbl_data[t][0], tbl_exp[t]);
            endcase
            n_failed += (n_errors != errs_before);
            $display("test %0d %s 0x%04h: %s", t, tbl_op[t].name(), tbl_addr[t],
                     (n_errors == errs_before) ? "ok" : "failed");
        end

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tbl_op.size() + 1, n_failed, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // Every entry gets the budget of a full-length run
    initial begin
        wait (table_ready);
        #((tbl_op.size() * ENTRY_CYCLES + 10) * 10);
        $display("Watchdog expired, the table did not complete in time");
        $display("Simulation FAILED");
        $finish;
    end

endmodule

// ==== hw/cfg_decoder.sv ====
// Host strobes reach a region one cycle later; o_cfg_rvalid follows i_cfg_rd by two cycles
`include "sauria_defs.svh"

module cfg_decoder (
    input  logic                          i_system_clk,
    input  logic                          i_rst_n,
    input  logic                          i_cfg_wr,
    input  logic                          i_cfg_rd,
    input  logic [`SAURIA_CFG_ADDR_W-1:0] i_cfg_addr,
    input  sauria_bus_pkg::word_t         i_cfg_wdata,
    output sauria_bus_pkg::word_t         o_cfg_rdata,
    output logic                          o_cfg_rvalid,
    cfg_if.master                         ctrl_cfg,
    cfg_if.master                         dma_cfg,
    cfg_if.master                         core_cfg
);
    import sauria_bus_pkg::*;
    import sauria_addr_pkg::*;

    logic      wr_q;
    logic      rd_q;
    cfg_addr_u addr_q;
    word_t     wdata_q;
    region_e   rsel_q;

    always_ff @(posedge i_system_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wr_q         <= 1'b0;
            rd_q         <= 1'b0;
            o_cfg_rvalid <= 1'b0;
            rsel_q       <= REGION_CTRL;
        end else begin
            wr_q         <= i_cfg_wr;
            rd_q         <= i_cfg_rd;
            o_cfg_rvalid <= rd_q;
            // Region of the read whose data comes back next cycle
            if (rd_q) begin
                rsel_q <= addr_q.reg_view.region;
            end
        end
    end

    always_ff @(posedge i_system_clk) begin
        addr_q  <= i_cfg_addr;
        wdata_q <= i_cfg_wdata;
    end

    // ------------------------------
    // Region strobes
    // ------------------------------
    assign ctrl_cfg.wr    = wr_q && (addr_q.reg_view.region == REGION_CTRL);
    assign ctrl_cfg.rd    = rd_q && (addr_q.reg_view.region == REGION_CTRL);
    assign dma_cfg.wr     = wr_q && (addr_q.reg_view.region == REGION_DMA);
    assign dma_cfg.rd     = rd_q && (addr_q.reg_view.region == REGION_DMA);
    assign core_cfg.wr    = wr_q && (addr_q.reg_view.region == REGION_CORE);
    assign core_cfg.rd    = rd_q && (addr_q.reg_view.region == REGION_CORE);
    assign ctrl_cfg.addr  = addr_q;
    assign dma_cfg.addr   = addr_q;
    assign core_cfg.addr  = addr_q;
    assign ctrl_cfg.wdata = wdata_q;
    assign dma_cfg.wdata  = wdata_q;
    assign core_cfg.wdata = wdata_q;

    // Unmapped regions read as zero
    always_comb begin
        case (rsel_q)
            REGION_CTRL: o_cfg_rdata = ctrl_cfg.rdata;
            REGION_DMA:  o_cfg_rdata = dma_cfg.rdata;
            REGION_CORE: o_cfg_rdata = core_cfg.rdata;
            default:     o_cfg_rdata = '0;
        endcase
    end

    // One access per cycle, never a write and a read together
    a_one_region: assert property (@(posedge i_system_clk) disable iff (!i_rst_n)
        $onehot0({ctrl_cfg.wr, ctrl_cfg.rd, dma_cfg.wr, dma_cfg.rd,
                  core_cfg.wr, core_cfg.rd}));

endmodule

// ==== hw/df_controller.sv ====
// One run at a time, DMA then core; START while busy is dropped and done stays until CLEAR
module df_controller (
    input  logic i_system_clk,
    input  logic i_rst_n,
    cfg_if.slave cfg,
    input  logic i_dma_done,
    input  logic i_core_done,
    output logic o_dma_start,
    output logic o_core_start,
    output logic o_intr
);
    import sauria_bus_pkg::*;
    import sauria_addr_pkg::*;

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_DMA  = 2'd1;
    localparam logic [1:0] ST_CORE = 2'd2;

    logic [1:0] state_q;
    logic       done_q;
    logic       intr_en_q;
    logic       busy;
    logic       start_wr;
    word_t      rdata_q;

    assign busy     = (state_q != ST_IDLE);
    assign start_wr = cfg.wr && (cfg.addr.reg_view.reg_idx == CTRL_START) && cfg.wdata[0];

    // ------------------------------
    // Run sequencer
    // ------------------------------
    always_ff @(posedge i_system_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q      <= ST_IDLE;
            done_q       <= 1'b0;
            intr_en_q    <= 1'b0;
            o_dma_start  <= 1'b0;
            o_core_start <= 1'b0;
            o_intr       <= 1'b0;
        end else begin
            o_dma_start  <= 1'b0;
            o_core_start <= 1'b0;
            o_intr       <= 1'b0;
            if (cfg.wr && (cfg.addr.reg_view.reg_idx == CTRL_INTR_EN)) begin
                intr_en_q <= cfg.wdata[0];
            end
            if (cfg.wr && (cfg.addr.reg_view.reg_idx == CTRL_CLEAR)) begin
                done_q <= 1'b0;
            end
            case (state_q)
                ST_IDLE: begin
                    if (start_wr) begin
                        state_q     <= ST_DMA;
                        o_dma_start <= 1'b1;
                        done_q      <= 1'b0;
                    end
                end
                ST_DMA: begin
                    if (i_dma_done) begin
                        state_q      <= ST_CORE;
                        o_core_start <= 1'b1;
                    end
                end
                ST_CORE: begin
                    // End of run wins over a CLEAR in the same cycle
                    if (i_core_done) begin
                        state_q <= ST_IDLE;
                        done_q  <= 1'b1;
                        o_intr  <= intr_en_q;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_system_clk) begin
        if (cfg.rd) begin
            case (cfg.addr.reg_view.reg_idx)
                CTRL_STATUS:  rdata_q <= word_t'({done_q, busy});
                CTRL_INTR_EN: rdata_q <= word_t'(intr_en_q);
                default:      rdata_q <= '0;
            endcase
        end
    end

    assign cfg.rdata = rdata_q;

    // Completion strobes only arrive in the state that waits for them
    a_dma_done_state: assert property (@(posedge i_system_clk) disable iff (!i_rst_n)
        i_dma_done |-> (state_q == ST_DMA));
    a_core_done_state: assert property (@(posedge i_system_clk) disable iff (!i_rst_n)
        i_core_done |-> (state_q == ST_CORE));

endmodule

// ==== hw/dma_engine.sv ====
// Copies LEN external words from SRC to local index 0 on; one word in flight, LEN 0 ends at once
module dma_engine (
    input  logic                      i_system_clk,
    input  logic                      i_rst_n,
    cfg_if.slave                      cfg,
    mem_port_if.requester             mem,
    input  logic                      i_dma_start,
    output logic                      o_ext_rd,
    output sauria_bus_pkg::ext_addr_t o_ext_addr,
    input  sauria_bus_pkg::word_t     i_ext_rdata,
    output logic                      o_dma_done
);
    import sauria_bus_pkg::*;
    import sauria_addr_pkg::*;

    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_READ  = 2'd1;
    localparam logic [1:0] ST_WRITE = 2'd2;

    logic [1:0] state_q;
    ext_addr_t  src_q;
    len_t       len_q;
    len_t       cnt_q;
    logic       ext_vld_q;
    word_t      data_q;
    word_t      rdata_q;

    always_ff @(posedge i_system_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q    <= ST_IDLE;
            src_q      <= '0;
            len_q      <= '0;
            cnt_q      <= '0;
            ext_vld_q  <= 1'b0;
            o_dma_done <= 1'b0;
        end else begin
            o_dma_done <= 1'b0;
            ext_vld_q  <= o_ext_rd;
            if (cfg.wr && (cfg.addr.reg_view.reg_idx == DMA_SRC)) begin
                src_q <= ext_addr_t'(cfg.wdata);
            end
            if (cfg.wr && (cfg.addr.reg_view.reg_idx == DMA_LEN)) begin
                len_q <= len_t'(cfg.wdata);
            end
            case (state_q)
                ST_IDLE: begin
                    if (i_dma_start) begin
                        cnt_q      <= '0;
                        state_q    <= (len_q == '0) ? ST_IDLE : ST_READ;
                        o_dma_done <= (len_q == '0);
                    end
                end
                ST_READ: state_q <= ST_WRITE;
                ST_WRITE: begin
                    if (mem.gnt) begin
                        cnt_q      <= cnt_q + 1'b1;
                        state_q    <= (cnt_q == len_q - 1'b1) ? ST_IDLE : ST_READ;
                        o_dma_done <= (cnt_q == len_q - 1'b1);
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // Hold the external word while the write waits for grant
    always_ff @(posedge i_system_clk) begin
        if (ext_vld_q) begin
            data_q <= i_ext_rdata;
        end
        if (cfg.rd) begin
            case (cfg.addr.reg_view.reg_idx)
                DMA_SRC: rdata_q <= word_t'(src_q);
                DMA_LEN: rdata_q <= word_t'(len_q);
                default: rdata_q <= '0;
            endcase
        end
    end

    assign o_ext_rd   = (state_q == ST_READ);
    assign o_ext_addr = src_q + ext_addr_t'(cnt_q);
    assign mem.req    = (state_q == ST_WRITE);
    assign mem.we     = 1'b1;
    assign mem.idx    = mem_idx_t'(cnt_q);
    assign mem.wdata  = ext_vld_q ? i_ext_rdata : data_q;
    assign cfg.rdata  = rdata_q;

    // A stalled write keeps its index and data until it is granted
    a_stall_stable: assert property (@(posedge i_system_clk) disable iff (!i_rst_n)
        (mem.req && !mem.gnt) |=> ($stable(mem.idx) && $stable(mem.wdata)));

endmodule

// ==== hw/mem_arbiter.sv ====
// Debug strobes always win the shared port; the core read port is independent and never stalls
`include "sauria_defs.svh"

module mem_arbiter (
    input  logic                     i_system_clk,
    input  logic                     i_rst_n,
    mem_port_if.arbiter              dma_port,
    cfg_if.slave                     debug_cfg,
    input  sauria_bus_pkg::mem_idx_t i_core_rd_idx,
    output sauria_bus_pkg::word_t    o_core_rd_data
);
    import sauria_bus_pkg::*;

    word_t    mem_q [`SAURIA_MEM_DEPTH];
    logic     dbg_act;
    logic     port_we;
    mem_idx_t port_idx;
    word_t    port_wdata;
    word_t    port_rdata_q;

    // ------------------------------
    // Fixed priority, debug first
    // ------------------------------
    assign dbg_act      = debug_cfg.wr || debug_cfg.rd;
    assign dma_port.gnt = dma_port.req && !dbg_act;
    assign port_we      = dbg_act ? debug_cfg.wr : (dma_port.gnt && dma_port.we);
    assign port_idx     = dbg_act ? debug_cfg.addr.mem_view.idx : dma_port.idx;
    assign port_wdata   = dbg_act ? debug_cfg.wdata : dma_port.wdata;

    always_ff @(posedge i_system_clk) begin
        if (port_we) begin
            mem_q[port_idx] <= port_wdata;
        end
        port_rdata_q   <= mem_q[port_idx];
        o_core_rd_data <= mem_q[i_core_rd_idx];
    end

    assign debug_cfg.rdata = port_rdata_q;
    assign dma_port.rdata  = port_rdata_q;

    // A DMA request turned away by debug traffic stays up until granted
    a_dma_req_held: assert property (@(posedge i_system_clk) disable iff (!i_rst_n)
        (dma_port.req && !dma_port.gnt) |=> dma_port.req);

endmodule

// ==== hw/sauria_addr_pkg.sv ====
// Host address map; 16-bit addresses, region in the top nibble, memory-select at bit 6
package sauria_addr_pkg;

    typedef enum logic [3:0] {
        REGION_CTRL = 4'h0,
        REGION_DMA  = 4'h1,
        REGION_CORE = 4'h2
    } region_e;

    typedef logic [3:0] reg_idx_t;

    // Register indices per region
    localparam reg_idx_t CTRL_START   = 4'd0;
    localparam reg_idx_t CTRL_STATUS  = 4'd1;
    localparam reg_idx_t CTRL_INTR_EN = 4'd2;
    localparam reg_idx_t CTRL_CLEAR   = 4'd3;
    localparam reg_idx_t DMA_SRC      = 4'd0;
    localparam reg_idx_t DMA_LEN      = 4'd1;
    localparam reg_idx_t CORE_LEN     = 4'd0;
    localparam reg_idx_t CORE_RESULT  = 4'd1;

    // Same address word seen as a register access or as a local memory access
    typedef union packed {
        struct packed {
            region_e    region;
            logic [4:0] rsvd_hi;
            logic       mem_sel;
            logic [1:0] rsvd_lo;
            reg_idx_t   reg_idx;
        } reg_view;
        struct packed {
            region_e                  region;
            logic [4:0]               rsvd;
            logic                     mem_sel;
            sauria_bus_pkg::mem_idx_t idx;
        } mem_view;
    } cfg_addr_u;

endpackage

// ==== hw/sauria_bus_pkg.sv ====
// Data-path types; widths come from the shared defines and must not be changed here
`include "sauria_defs.svh"

package sauria_bus_pkg;

    // Data word on the host bus and in local memory
    typedef logic [`SAURIA_WORD_W-1:0]     word_t;

    // Local memory word index
    typedef logic [`SAURIA_MEM_IDX_W-1:0]  mem_idx_t;

    // External memory word address
    typedef logic [`SAURIA_EXT_ADDR_W-1:0] ext_addr_t;

    // Transfer or sum length, 1 to MEM_DEPTH
    typedef logic [`SAURIA_LEN_W-1:0]      len_t;

endpackage

// ==== hw/sauria_core.sv ====
// Sums local words 0 to LEN-1 modulo 2^32; LEN 0 finishes at once and RESULT reads 0 meanwhile
module sauria_core (
    input  logic                     i_system_clk,
    input  logic                     i_rst_n,
    cfg_if.slave                     cfg,
    cfg_if.master                    mem_cfg,
    input  logic                     i_core_start,
    output sauria_bus_pkg::mem_idx_t o_core_rd_idx,
    input  sauria_bus_pkg::word_t    i_core_rd_data,
    output logic                     o_core_done
);
    import sauria_bus_pkg::*;
    import sauria_addr_pkg::*;

    logic  mem_sel;
    logic  mem_rd_q;
    len_t  len_q;
    len_t  idx_q;
    logic  run_q;
    logic  vld_q;
    logic  last_q;
    word_t result_q;
    word_t reg_rdata_q;

    // ------------------------------
    // Memory window forwarding
    // ------------------------------
    assign mem_sel       = cfg.addr.reg_view.mem_sel;
    assign mem_cfg.wr    = cfg.wr && mem_sel;
    assign mem_cfg.rd    = cfg.rd && mem_sel;
    assign mem_cfg.addr  = cfg.addr;
    assign mem_cfg.wdata = cfg.wdata;
    assign cfg.rdata     = mem_rd_q ? mem_cfg.rdata : reg_rdata_q;

    always_ff @(posedge i_system_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            mem_rd_q    <= 1'b0;
            len_q       <= '0;
            idx_q       <= '0;
            run_q       <= 1'b0;
            vld_q       <= 1'b0;
            last_q      <= 1'b0;
            result_q    <= '0;
            o_core_done <= 1'b0;
        end else begin
            if (cfg.rd) begin
                mem_rd_q <= mem_sel;
            end
            if (cfg.wr && !mem_sel && (cfg.addr.reg_view.reg_idx == CORE_LEN)) begin
                len_q <= len_t'(cfg.wdata);
            end
            // Read issue, one word per cycle
            vld_q  <= run_q;
            last_q <= run_q && (idx_q == len_q - 1'b1);
            if (i_core_start && !run_q) begin
                idx_q    <= '0;
                run_q    <= (len_q != '0);
                result_q <= '0;
            end else if (run_q) begin
                idx_q <= idx_q + 1'b1;
                run_q <= (idx_q != len_q - 1'b1);
            end
            // Accumulate, one cycle behind the issue
            if (vld_q) begin
                result_q <= result_q + i_core_rd_data;
            end
            o_core_done <= (vld_q && last_q) || (i_core_start && !run_q && (len_q == '0));
        end
    end

    always_ff @(posedge i_system_clk) begin
        if (cfg.rd && !mem_sel) begin
            case (cfg.addr.reg_view.reg_idx)
                CORE_LEN:    reg_rdata_q <= word_t'(len_q);
                CORE_RESULT: reg_rdata_q <= result_q;
                default:     reg_rdata_q <= '0;
            endcase
        end
    end

    assign o_core_rd_idx = mem_idx_t'(idx_q);

endmodule

// ==== hw/sauria_defs.svh ====
// Widths and depths for one clock domain; MEM_IDX_W must equal clog2(MEM_DEPTH), LEN_W one more
`ifndef SAURIA_DEFS_SVH
`define SAURIA_DEFS_SVH

// Host configuration bus
`define SAURIA_CFG_ADDR_W 16
`define SAURIA_WORD_W     32

// Local memory, word addressed
`define SAURIA_MEM_DEPTH  64
`define SAURIA_MEM_IDX_W  6

// External memory word address
`define SAURIA_EXT_ADDR_W 16

// Lengths run from 1 to MEM_DEPTH
`define SAURIA_LEN_W      7

`endif

// ==== hw/sauria_ifs.sv ====
// Strobe bus with rdata one cycle after rd; memory port accepts on req and gnt, rdata a cycle later

interface cfg_if;
    import sauria_bus_pkg::*;
    import sauria_addr_pkg::*;

    logic      wr;
    logic      rd;
    cfg_addr_u addr;
    word_t     wdata;
    word_t     rdata;

    modport master (output wr, rd, addr, wdata, input rdata);
    modport slave  (input wr, rd, addr, wdata, output rdata);
endinterface

interface mem_port_if;
    import sauria_bus_pkg::*;

    logic     req;
    logic     we;
    mem_idx_t idx;
    word_t    wdata;
    logic     gnt;
    word_t    rdata;

    modport requester (output req, we, idx, wdata, input gnt, rdata);
    modport arbiter   (input req, we, idx, wdata, output gnt, rdata);
endinterface

// ==== hw/sauria_subsystem.sv ====
// Single clock, no back-pressure on the host bus; external read data must follow o_ext_rd by one cycle
`include "sauria_defs.svh"

module sauria_subsystem (
    input  logic                          i_system_clk,
    input  logic                          i_rst_n,
    input  logic                          i_cfg_wr,
    input  logic                          i_cfg_rd,
    input  logic [`SAURIA_CFG_ADDR_W-1:0] i_cfg_addr,
    input  sauria_bus_pkg::word_t         i_cfg_wdata,
    output sauria_bus_pkg::word_t         o_cfg_rdata,
    output logic                          o_cfg_rvalid,
    output logic                          o_ext_rd,
    output sauria_bus_pkg::ext_addr_t     o_ext_addr,
    input  sauria_bus_pkg::word_t         i_ext_rdata,
    output logic                          o_intr,
    output logic                          o_dma_intr,
    output logic                          o_core_intr
);
    import sauria_bus_pkg::*;

    logic     dma_start;
    logic     core_start;
    mem_idx_t core_rd_idx;
    word_t    core_rd_data;

    cfg_if      ctrl_cfg ();
    cfg_if      dma_cfg ();
    cfg_if      core_cfg ();
    cfg_if      mem_dbg_cfg ();
    mem_port_if dma_mem ();

    // ------------------------------
    // Host side
    // ------------------------------
    cfg_decoder cfg_decoder_i (
        .i_system_clk (i_system_clk),
        .i_rst_n      (i_rst_n),
        .i_cfg_wr     (i_cfg_wr),
        .i_cfg_rd     (i_cfg_rd),
        .i_cfg_addr   (i_cfg_addr),
        .i_cfg_wdata  (i_cfg_wdata),
        .o_cfg_rdata  (o_cfg_rdata),
        .o_cfg_rvalid (o_cfg_rvalid),
        .ctrl_cfg     (ctrl_cfg),
        .dma_cfg      (dma_cfg),
        .core_cfg     (core_cfg)
    );

    // Completion strobes double as the DMA and core interrupts
    df_controller df_controller_i (
        .i_system_clk (i_system_clk),
        .i_rst_n      (i_rst_n),
        .cfg          (ctrl_cfg),
        .i_dma_done   (o_dma_intr),
        .i_core_done  (o_core_intr),
        .o_dma_start  (dma_start),
        .o_core_start (core_start),
        .o_intr       (o_intr)
    );

    // ------------------------------
    // Data path
    // ------------------------------
    dma_engine dma_engine_i (
        .i_system_clk (i_system_clk),
        .i_rst_n      (i_rst_n),
        .cfg          (dma_cfg),
        .mem          (dma_mem),
        .i_dma_start  (dma_start),
        .o_ext_rd     (o_ext_rd),
        .o_ext_addr   (o_ext_addr),
        .i_ext_rdata  (i_ext_rdata),
        .o_dma_done   (o_dma_intr)
    );

    sauria_core sauria_core_i (
        .i_system_clk   (i_system_clk),
        .i_rst_n        (i_rst_n),
        .cfg            (core_cfg),
        .mem_cfg        (mem_dbg_cfg),
        .i_core_start   (core_start),
        .o_core_rd_idx  (core_rd_idx),
        .i_core_rd_data (core_rd_data),
        .o_core_done    (o_core_intr)
    );

    mem_arbiter mem_arbiter_i (
        .i_system_clk   (i_system_clk),
        .i_rst_n        (i_rst_n),
        .dma_port       (dma_mem),
        .debug_cfg      (mem_dbg_cfg),
        .i_core_rd_idx  (core_rd_idx),
        .o_core_rd_data (core_rd_data)
    );

endmodule

// ==== sauria_lite.f ====
+incdir+hw
hw/sauria_bus_pkg.sv
hw/sauria_addr_pkg.sv
hw/sauria_ifs.sv
hw/cfg_decoder.sv
hw/df_controller.sv
hw/dma_engine.sv
hw/mem_arbiter.sv
hw/sauria_core.sv
hw/sauria_subsystem.sv
dv/tb_sauria_subsystem.sv
